// ==== hw/rdma_wr_consts.svh ====
// ------------------------------------------------
// Widths and default depths of the RDMA write path
// Queue depths must be 2 or more
// ------------------------------------------------
`ifndef RDMA_WR_CONSTS_SVH
`define RDMA_WR_CONSTS_SVH

// Stream payload
`define RDMA_DATA_BITS 64
`define RDMA_TID_BITS 6

// Request fields
`define RDMA_PID_BITS 6
`define RDMA_VADDR_BITS 48
`define RDMA_BLEN_BITS 8

// Default buffer depths
`define RDMA_DATA_DEPTH 16
`define RDMA_META_DEPTH 4

`endif

// ==== hw/rdma_wr_pkg.sv ====
// ------------------------------------------------
// Shared types of the write path
// len counts beats minus one
// ------------------------------------------------
`default_nettype none

`include "rdma_wr_consts.svh"

package rdma_wr_pkg;

  // ------------------------------------------------
  // Write request
  // ------------------------------------------------
  // Process id selects host or card
  // Length is number of beats minus one
  typedef struct packed {
    logic [`RDMA_PID_BITS-1:0]   pid;
    logic [`RDMA_VADDR_BITS-1:0] vaddr;
    logic [`RDMA_BLEN_BITS-1:0]  len;
  } wr_req_t;

  // ------------------------------------------------
  // Stream beat
  // ------------------------------------------------
  // One byte enable per data byte
  typedef struct packed {
    logic [`RDMA_DATA_BITS-1:0]     tdata;
    logic [`RDMA_DATA_BITS/8-1:0]   tkeep;
    logic                           tlast;
    logic [`RDMA_TID_BITS-1:0]      tid;
  } axis_beat_t;

  // ------------------------------------------------
  // Destination mux FSM
  // ------------------------------------------------
  // Idle waits for a request
  // Mux streams the current transfer
  typedef enum logic [0:0] {
    ST_IDLE = 1'b0,
    ST_MUX  = 1'b1
  } mux_state_e;

endpackage

`default_nettype wire

// ==== hw/meta_queue.sv ====
// ------------------------------------------------
// Request FIFO, DEPTH of 2 or more, ready is not full
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module meta_queue #(
  parameter int DEPTH = 4
) (
  input  wire logic                 aclk,
  input  wire logic                 aresetn,
  input  wire logic                 s_valid,
  output logic                      s_ready,
  input  wire rdma_wr_pkg::wr_req_t s_req,
  output logic                      m_valid,
  input  wire logic                 m_ready,
  output rdma_wr_pkg::wr_req_t      m_req
);

  // Pointer and occupancy widths
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // Entry storage
  rdma_wr_pkg::wr_req_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  // Handshakes
  assign s_ready = (count != CW'(DEPTH));
  assign m_valid = (count != '0);
  assign push    = s_valid && s_ready;
  assign pop     = m_valid && m_ready;

  // Head entry straight from storage
  assign m_req = mem[rd_ptr];

  // Write port
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_req;
    end
  end

  // Pointers and count
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at DEPTH-1
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/axis_data_fifo.sv ====
// ------------------------------------------------
// Stream beat FIFO, DEPTH of 2 or more, ready is not full
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axis_data_fifo #(
  parameter int DEPTH = 16
) (
  input  wire logic                    aclk,
  input  wire logic                    aresetn,
  input  wire logic                    s_valid,
  output logic                         s_ready,
  input  wire rdma_wr_pkg::axis_beat_t s_beat,
  output logic                         m_valid,
  input  wire logic                    m_ready,
  output rdma_wr_pkg::axis_beat_t      m_beat
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // ------------------------------------------------
  // Storage and state
  // ------------------------------------------------
  // Whole beat kept as one word
  rdma_wr_pkg::axis_beat_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [CW-1:0] count_next;
  logic          full;
  logic          empty;
  logic          wr_en;
  logic          rd_en;

  // ------------------------------------------------
  // Handshakes
  // ------------------------------------------------
  assign s_ready = !full;
  assign m_valid = !empty;
  assign wr_en   = s_valid && !full;
  assign rd_en   = m_ready && !empty;

  // Oldest beat, passed as stored
  assign m_beat = mem[rd_ptr];

  // Occupancy after this edge
  always_comb begin
    count_next = count;
    if (wr_en && !rd_en) begin
      count_next = count + 1'b1;
    end else if (rd_en && !wr_en) begin
      count_next = count - 1'b1;
    end
  end

  // ------------------------------------------------
  // Registers
  // ------------------------------------------------
  // Beat write
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= s_beat;
    end
  end

  // Pointers, count and flags
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      // Flags from next count, so no extra cycle
      full  <= (count_next == CW'(DEPTH));
      empty <= (count_next == '0);
    end
  end

endmodule

`default_nettype wire

// ==== hw/wr_dest_mux.sv ====
// ------------------------------------------------
// Steers len+1 beats per request to host or card
// tlast is not checked, the beat counter ends a transfer
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "rdma_wr_consts.svh"

module wr_dest_mux (
  input  wire logic                        aclk,
  input  wire logic                        aresetn,
  input  wire logic [`RDMA_PID_BITS-1:0]   mux_ctid,

  // Incoming requests
  input  wire logic                        s_rq_valid,
  output logic                             s_rq_ready,
  input  wire rdma_wr_pkg::wr_req_t        s_rq_req,

  // Forwarded requests
  output logic                             sq_valid,
  input  wire logic                        sq_ready,
  output rdma_wr_pkg::wr_req_t             sq_req,

  // Buffered beats
  input  wire logic                        int_valid,
  output logic                             int_ready,
  input  wire rdma_wr_pkg::axis_beat_t     int_beat,

  // Host side
  output logic                             host_valid,
  input  wire logic                        host_ready,
  output rdma_wr_pkg::axis_beat_t          host_beat,

  // Card side
  output logic                             card_valid,
  input  wire logic                        card_ready,
  output rdma_wr_pkg::axis_beat_t          card_beat
);

  // ------------------------------------------------
  // State
  // ------------------------------------------------
  rdma_wr_pkg::mux_state_e      state_q;
  rdma_wr_pkg::mux_state_e      state_d;
  logic [`RDMA_BLEN_BITS-1:0]   cnt_q;
  logic [`RDMA_BLEN_BITS-1:0]   cnt_d;
  logic                         host_q;
  logic                         host_d;

  logic active;
  logic beat_fire;
  logic tr_done;
  logic take;

  // Streaming only in ST_MUX
  assign active    = (state_q == rdma_wr_pkg::ST_MUX);
  assign beat_fire = int_valid && int_ready;
  // Last beat of the current transfer
  assign tr_done   = active && (cnt_q == '0) && beat_fire;

  // New request allowed when idle or on the final beat
  assign take = s_rq_valid && sq_ready && (!active || tr_done);

  // ------------------------------------------------
  // Request hand-off
  // ------------------------------------------------
  // Same-cycle pass to the send queue
  assign s_rq_ready = take;
  assign sq_valid   = take;
  assign sq_req     = s_rq_req;

  // ------------------------------------------------
  // Beat steering
  // ------------------------------------------------
  always_comb begin
    host_valid = 1'b0;
    host_beat  = '0;
    card_valid = 1'b0;
    card_beat  = '0;
    int_ready  = 1'b0;
    if (active) begin
      if (host_q) begin
        host_valid = int_valid;
        host_beat  = int_beat;
        int_ready  = host_ready;
      end else begin
        card_valid = int_valid;
        card_beat  = int_beat;
        int_ready  = card_ready;
      end
    end
  end

  // ------------------------------------------------
  // Next state, counter and destination
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    host_d  = host_q;
    case (state_q)
      rdma_wr_pkg::ST_IDLE: begin
        if (take) begin
          state_d = rdma_wr_pkg::ST_MUX;
        end
      end
      rdma_wr_pkg::ST_MUX: begin
        // Back-to-back request stays in ST_MUX
        if (tr_done && !take) begin
          state_d = rdma_wr_pkg::ST_IDLE;
        end
      end
      default: state_d = rdma_wr_pkg::ST_IDLE;
    endcase
    // Load on take, else count down accepted beats
    if (take) begin
      cnt_d  = s_rq_req.len;
      host_d = (s_rq_req.pid == mux_ctid);
    end else if (active && beat_fire && (cnt_q != '0)) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= rdma_wr_pkg::ST_IDLE;
      cnt_q   <= '0;
      host_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      host_q  <= host_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rdma_wr_top.sv ====
// ------------------------------------------------
// Write-data path, data FIFO into mux, request queue after it
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "rdma_wr_consts.svh"

module rdma_wr_top (
  input  wire logic                      aclk,
  input  wire logic                      aresetn,
  input  wire logic [`RDMA_PID_BITS-1:0] mux_ctid,

  // Requests in
  input  wire logic                      s_rq_valid,
  output logic                           s_rq_ready,
  input  wire rdma_wr_pkg::wr_req_t      s_rq_req,

  // Send queue out
  output logic                           m_sq_valid,
  input  wire logic                      m_sq_ready,
  output rdma_wr_pkg::wr_req_t           m_sq_req,

  // Data stream in
  input  wire logic                      s_axis_valid,
  output logic                           s_axis_ready,
  input  wire rdma_wr_pkg::axis_beat_t   s_axis_beat,

  // Host stream out
  output logic                           m_axis_host_valid,
  input  wire logic                      m_axis_host_ready,
  output rdma_wr_pkg::axis_beat_t        m_axis_host_beat,

  // Card stream out
  output logic                           m_axis_card_valid,
  input  wire logic                      m_axis_card_ready,
  output rdma_wr_pkg::axis_beat_t        m_axis_card_beat
);

  // Mux to send queue
  logic                    sq_valid;
  logic                    sq_ready;
  rdma_wr_pkg::wr_req_t    sq_req;

  // Data FIFO to mux
  logic                    int_valid;
  logic                    int_ready;
  rdma_wr_pkg::axis_beat_t int_beat;

  axis_data_fifo #(.DEPTH(`RDMA_DATA_DEPTH)) inst_data_fifo (
    .aclk(aclk), .aresetn(aresetn),
    .s_valid(s_axis_valid), .s_ready(s_axis_ready), .s_beat(s_axis_beat),
    .m_valid(int_valid), .m_ready(int_ready), .m_beat(int_beat)
  );

  wr_dest_mux inst_mux (
    .aclk(aclk), .aresetn(aresetn), .mux_ctid(mux_ctid),
    .s_rq_valid(s_rq_valid), .s_rq_ready(s_rq_ready), .s_rq_req(s_rq_req),
    .sq_valid(sq_valid), .sq_ready(sq_ready), .sq_req(sq_req),
    .int_valid(int_valid), .int_ready(int_ready), .int_beat(int_beat),
    .host_valid(m_axis_host_valid), .host_ready(m_axis_host_ready),
    .host_beat(m_axis_host_beat),
    .card_valid(m_axis_card_valid), .card_ready(m_axis_card_ready),
    .card_beat(m_axis_card_beat)
  );

  meta_queue #(.DEPTH(`RDMA_META_DEPTH)) inst_queue_sq (
    .aclk(aclk), .aresetn(aresetn),
    .s_valid(sq_valid), .s_ready(sq_ready), .s_req(sq_req),
    .m_valid(m_sq_valid), .m_ready(m_sq_ready), .m_req(m_sq_req)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_rdma_wr_tasks.svh ====
// ------------------------------------------------
// Drivers, checks and tests, included in tb_rdma_wr
// Drivers are entered and left at a falling edge
// ------------------------------------------------

// ------------------------------------------------
// Compare tasks
// ------------------------------------------------
task automatic check_req(input string name, input rdma_wr_pkg::wr_req_t got,
                         input rdma_wr_pkg::wr_req_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_beat(input string name, input rdma_wr_pkg::axis_beat_t got,
                          input rdma_wr_pkg::axis_beat_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    value_errors++;
    $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

// Output beat against the model queues
task automatic take_beat(input logic to_host, input rdma_wr_pkg::axis_beat_t beat);
  if (exp_dest.size() == 0 || exp_beats.size() == 0) begin
    other_errors++;
    $display("Beat left the DUT at %0t with no request or input beat owed", $time);
  end else begin
    check_bit("beat goes to host", to_host, exp_dest.pop_front());
    check_beat(to_host ? "m_axis_host_beat" : "m_axis_card_beat", beat, exp_beats.pop_front());
  end
endtask

// Random request to host or card
function automatic rdma_wr_pkg::wr_req_t make_req(input logic to_host, input int len);
  rdma_wr_pkg::wr_req_t req;
  logic [63:0]          addr;
  addr = {$urandom(), $urandom()};
  req.vaddr = addr[`RDMA_VADDR_BITS-1:0];
  req.len = len[`RDMA_BLEN_BITS-1:0];
  // XOR with a nonzero value gives another pid
  if (to_host) begin
    req.pid = mux_ctid;
  end else begin
    req.pid = mux_ctid ^ `RDMA_PID_BITS'($urandom_range(1, (1 << `RDMA_PID_BITS) - 1));
  end
  return req;
endfunction

// ------------------------------------------------
// Drivers and waits
// ------------------------------------------------
task automatic wait_rq_accept();
  int t;
  t = 0;
  // Ready sampled at the rising edge that takes the request
  do begin
    @(posedge aclk);
    t++;
  end while (!s_rq_ready && t < TIMEOUT);
  if (!s_rq_ready) begin
    other_errors++;
    $display("Timeout at %0t: request with pid %h was never accepted", $time, s_rq_req.pid);
  end
  @(negedge aclk);
  s_rq_valid = 1'b0;
  s_rq_req = '0;
endtask

task automatic send_req(input rdma_wr_pkg::wr_req_t req);
  s_rq_valid = 1'b1;
  s_rq_req = req;
  wait_rq_accept();
endtask

// n beats, tlast on the final one
task automatic send_beats(input int n);
  rdma_wr_pkg::axis_beat_t b;
  logic [31:0]             r;
  int                      t;
  for (int k = 0; k < n; k++) begin
    r = $urandom();
    b.tdata = {$urandom(), $urandom()};
    b.tkeep = r[`RDMA_DATA_BITS/8-1:0];
    b.tid = r[16 +: `RDMA_TID_BITS];
    b.tlast = (k == n - 1);
    s_axis_valid = 1'b1;
    s_axis_beat = b;
    t = 0;
    do begin
      @(posedge aclk);
      t++;
    end while (!s_axis_ready && t < TIMEOUT);
    if (!s_axis_ready) begin
      other_errors++;
      $display("Timeout at %0t: data FIFO never took beat %0d", $time, k);
    end
    @(negedge aclk);
  end
  s_axis_valid = 1'b0;
  s_axis_beat = '0;
endtask

task automatic wait_beats_in(input int n);
  int t;
  t = 0;
  while (beats_in < n && t < TIMEOUT) begin
    @(negedge aclk);
    t++;
  end
  if (beats_in < n) begin
    other_errors++;
    $display("Timeout at %0t: only %0d of %0d beats entered", $time, beats_in, n);
  end
endtask

// Everything owed has left, the send queue too if asked
task automatic wait_drain(input logic with_sq);
  int t;
  t = 0;
  while ((exp_dest.size() != 0 || exp_beats.size() != 0 || (with_sq && exp_sq.size() != 0))
         && t < TIMEOUT) begin
    @(negedge aclk);
    t++;
  end
  if (t >= TIMEOUT) begin
    other_errors++;
    $display("Timeout at %0t: %0d beats and %0d requests never came out",
             $time, exp_beats.size(), exp_sq.size());
  end
endtask

// ------------------------------------------------
// Directed tests
// ------------------------------------------------
task automatic test_reset();
  @(posedge aclk);
  check_bit("m_axis_host_valid", m_axis_host_valid, 1'b0);
  check_bit("m_axis_card_valid", m_axis_card_valid, 1'b0);
  check_bit("m_sq_valid", m_sq_valid, 1'b0);
  check_bit("s_rq_ready", s_rq_ready, 1'b0);
  check_bit("s_axis_ready", s_axis_ready, 1'b1);
  check_bit("mux state idle", UUT.inst_mux.state_q == rdma_wr_pkg::ST_IDLE, 1'b1);
  @(negedge aclk);
endtask

task automatic test_host();
  rdma_wr_pkg::wr_req_t req;
  req = make_req(1'b1, 3);
  fork
    send_req(req);
    send_beats(4);
  join
  wait_drain(1'b1);
endtask

// Host and card in turn, requests queued behind each other
task automatic test_alternate();
  rdma_wr_pkg::wr_req_t reqs[6];
  int                   total;
  total = 0;
  for (int i = 0; i < 6; i++) begin
    reqs[i] = make_req(i % 2 == 0, $urandom_range(0, 7));
    total += int'(reqs[i].len) + 1;
  end
  fork
    for (int i = 0; i < 6; i++) begin
      send_req(reqs[i]);
    end
    send_beats(total);
  join
  wait_drain(1'b1);
endtask

task automatic test_sq_stall();
  rdma_wr_pkg::wr_req_t reqs[5];
  int                   total;
  total = 0;
  m_sq_ready = 1'b0;
  for (int i = 0; i < 4; i++) begin
    reqs[i] = make_req(i % 2 == 1, $urandom_range(0, 3));
    total += int'(reqs[i].len) + 1;
  end
  reqs[4] = make_req(1'b1, 2);
  fork
    for (int i = 0; i < 4; i++) begin
      send_req(reqs[i]);
    end
    send_beats(total);
  join
  // Owed data drains while the queue is stuck
  wait_drain(1'b0);
  check_bit("m_sq_valid", m_sq_valid, 1'b1);
  // Queue full so the fifth request waits
  s_rq_valid = 1'b1;
  s_rq_req = reqs[4];
  repeat (8) begin
    @(posedge aclk);
    check_bit("s_rq_ready", s_rq_ready, 1'b0);
  end
  @(negedge aclk);
  m_sq_ready = 1'b1;
  fork
    wait_rq_accept();
    send_beats(3);
  join
  wait_drain(1'b1);
endtask

// Random output ready, data ahead of its request
task automatic test_random_ready();
  rdma_wr_pkg::wr_req_t reqs[5];
  int                   total;
  int                   base;
  total = 0;
  @(posedge aclk);
  rand_ready = 1'b1;
  @(negedge aclk);
  for (int i = 0; i < 5; i++) begin
    reqs[i] = make_req($urandom_range(0, 1) == 1, $urandom_range(0, 5));
    total += int'(reqs[i].len) + 1;
  end
  base = beats_in;
  fork
    send_beats(total);
    begin
      wait_beats_in(base + int'(reqs[0].len) + 1);
      for (int i = 0; i < 5; i++) begin
        send_req(reqs[i]);
      end
    end
  join
  wait_drain(1'b1);
  @(posedge aclk);
  rand_ready = 1'b0;
  @(negedge aclk);
endtask

// ==== testbench/tb_rdma_wr.sv ====
// ------------------------------------------------
// Directed tests of rdma_wr_top against a queue model
// Every wait is bounded by TIMEOUT cycles
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "rdma_wr_consts.svh"

module tb_rdma_wr;

  localparam int TIMEOUT = 400;

  // ------------------------------------------------
  // DUT signals
  // ------------------------------------------------
  logic                      aclk;
  logic                      aresetn;
  logic [`RDMA_PID_BITS-1:0] mux_ctid;
  logic                      s_rq_valid;
  logic                      s_rq_ready;
  rdma_wr_pkg::wr_req_t      s_rq_req;
  logic                      m_sq_valid;
  logic                      m_sq_ready;
  rdma_wr_pkg::wr_req_t      m_sq_req;
  logic                      s_axis_valid;
  logic                      s_axis_ready;
  rdma_wr_pkg::axis_beat_t   s_axis_beat;
  logic                      m_axis_host_valid;
  logic                      m_axis_host_ready;
  rdma_wr_pkg::axis_beat_t   m_axis_host_beat;
  logic                      m_axis_card_valid;
  logic                      m_axis_card_ready;
  rdma_wr_pkg::axis_beat_t   m_axis_card_beat;

  // Reference model
  rdma_wr_pkg::wr_req_t    exp_sq[$];
  rdma_wr_pkg::axis_beat_t exp_beats[$];
  // One entry per owed beat, 1 for host
  logic                    exp_dest[$];
  int                      beats_in;
  int                      value_errors;
  int                      other_errors;
  logic                    rand_ready;

  rdma_wr_top UUT (
    .aclk(aclk), .aresetn(aresetn), .mux_ctid(mux_ctid),
    .s_rq_valid(s_rq_valid), .s_rq_ready(s_rq_ready), .s_rq_req(s_rq_req),
    .m_sq_valid(m_sq_valid), .m_sq_ready(m_sq_ready), .m_sq_req(m_sq_req),
    .s_axis_valid(s_axis_valid), .s_axis_ready(s_axis_ready), .s_axis_beat(s_axis_beat),
    .m_axis_host_valid(m_axis_host_valid), .m_axis_host_ready(m_axis_host_ready),
    .m_axis_host_beat(m_axis_host_beat),
    .m_axis_card_valid(m_axis_card_valid), .m_axis_card_ready(m_axis_card_ready),
    .m_axis_card_beat(m_axis_card_beat)
  );

  always #2 aclk = ~aclk;

  // Output back-pressure, random or always ready
  always @(negedge aclk) begin
    if (rand_ready) begin
      m_axis_host_ready = ($urandom_range(0, 1) == 1);
      m_axis_card_ready = ($urandom_range(0, 1) == 1);
    end else begin
      m_axis_host_ready = 1'b1;
      m_axis_card_ready = 1'b1;
    end
  end

  `include "tb_rdma_wr_tasks.svh"

  // ------------------------------------------------
  // Monitors
  // ------------------------------------------------
  always @(posedge aclk) begin
    if (aresetn) begin
      // Accepted request owes len+1 beats to one side
      if (s_rq_valid && s_rq_ready) begin
        exp_sq.push_back(s_rq_req);
        for (int i = 0; i <= int'(s_rq_req.len); i++) begin
          exp_dest.push_back(s_rq_req.pid == mux_ctid);
        end
      end
      if (s_axis_valid && s_axis_ready) begin
        exp_beats.push_back(s_axis_beat);
        beats_in++;
      end
      // Never both sides at once
      check_bit("host and card valid", m_axis_host_valid && m_axis_card_valid, 1'b0);
      // Unused side carries a zero beat
      if (m_axis_host_valid) begin
        check_beat("m_axis_card_beat", m_axis_card_beat, '0);
      end
      if (m_axis_card_valid) begin
        check_beat("m_axis_host_beat", m_axis_host_beat, '0);
      end
      if (m_axis_host_valid && m_axis_host_ready) begin
        take_beat(1'b1, m_axis_host_beat);
      end
      if (m_axis_card_valid && m_axis_card_ready) begin
        take_beat(1'b0, m_axis_card_beat);
      end
      if (m_sq_valid && m_sq_ready) begin
        if (exp_sq.size() == 0) begin
          other_errors++;
          $display("Send queue output at %0t without an accepted request", $time);
        end else begin
          check_req("m_sq_req", m_sq_req, exp_sq.pop_front());
        end
      end
    end
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin
    int unsigned seed;
    seed = $urandom(88697);
    aclk = 1'b0;
    aresetn = 1'b0;
    mux_ctid = `RDMA_PID_BITS'(6'h0a);
    s_rq_valid = 1'b0;
    s_rq_req = '0;
    m_sq_ready = 1'b1;
    s_axis_valid = 1'b0;
    s_axis_beat = '0;
    m_axis_host_ready = 1'b1;
    m_axis_card_ready = 1'b1;
    beats_in = 0;
    value_errors = 0;
    other_errors = 0;
    rand_ready = 1'b0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    test_reset();
    test_host();
    test_alternate();
    test_sq_stall();
    test_random_ready();
    $display("Done with %0d value errors and %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
+incdir+testbench
hw/rdma_wr_pkg.sv
hw/meta_queue.sv
hw/axis_data_fifo.sv
hw/wr_dest_mux.sv
hw/rdma_wr_top.sv
testbench/tb_rdma_wr.sv

// ==== Bender.yml ====
package:
  name: rdma_wr

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rdma_wr_pkg.sv
      - hw/meta_queue.sv
      - hw/axis_data_fifo.sv
      - hw/wr_dest_mux.sv
      - hw/rdma_wr_top.sv
  - target: simulation
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/tb_rdma_wr.sv
